//--- aesCbcTb.sv
// testbench for the AES-128 CBC block cipher
// applies a table of key loads and requests, collects results under random back-pressure
`timescale 1ns/1ns

module aesCbcTb
    import aesStreamPkg::*;
();

    typedef struct packed {
        logic  newKey;
        blockT key;
        logic  decrypt;
        logic  chain;
        blockT din;
        blockT expBlock;
    } stimRowT;

    localparam int numRows = 6;
    localparam blockT testKey = 128'h000102030405060708090a0b0c0d0e0f;
    localparam blockT plainA = 128'h00112233445566778899aabbccddeeff;
    localparam blockT cipherA = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

    logic   clk = 1'b0;
    logic   rst;
    blockT  key;
    logic   keyLoad;
    logic   keyReady;
    logic   inValid;
    logic   inReady;
    aesReqT inReq;
    logic   outValid;
    logic   outReady;
    blockT  outBlock;

    stimRowT stim [numRows];
    int      seed = 57890;
    int      errorCount = 0;
    int      checkCount = 0;
    int      outIdx = 0;
    int      cycleCount = 0;
    int      cycleLimit = 0;

    aesCbcTop uut (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .keyLoad  (keyLoad),
        .keyReady (keyReady),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .outValid (outValid),
        .outReady (outReady),
        .outBlock (outBlock)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic checkValue(string name, logic [127:0] got, logic [127:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("** Error %s: got %0h, expected %0h", name, got, want);
        end
    endtask

    function automatic stimRowT makeRow(logic newKey, logic decrypt, logic chain,
                                        blockT din, blockT expBlock);
        stimRowT r;
        r.newKey = newKey;
        r.key = testKey;
        r.decrypt = decrypt;
        r.chain = chain;
        r.din = din;
        r.expBlock = expBlock;
        return r;
    endfunction

    // ECB both ways, then CBC encryption and CBC decryption, each after a fresh key
    // the second CBC plaintext is pre-XORed with the first ciphertext so chaining cancels it
    task automatic fillStimulus();
        stim[0] = makeRow(1'b1, 1'b0, 1'b0, plainA, cipherA);
        stim[1] = makeRow(1'b0, 1'b1, 1'b0, cipherA, plainA);
        stim[2] = makeRow(1'b1, 1'b0, 1'b1, plainA, cipherA);
        stim[3] = makeRow(1'b0, 1'b0, 1'b1, plainA ^ cipherA, cipherA);
        stim[4] = makeRow(1'b1, 1'b1, 1'b1, cipherA, plainA);
        stim[5] = makeRow(1'b0, 1'b1, 1'b1, cipherA, plainA ^ cipherA);
    endtask

    function automatic int timeoutCycles();
        int limit;
        limit = 0;
        for (int i = 0; i < numRows; i++) begin
            limit += stim[i].newKey ? 80 : 60;
        end
        return limit;
    endfunction

    // the schedule should come back ready ten edges after the edge that takes keyLoad
    task automatic loadCipherKey(blockT k);
        int waited;
        @(negedge clk);
        key = k;
        keyLoad = 1'b1;
        @(negedge clk);
        keyLoad = 1'b0;
        checkValue("keyReady", keyReady, 1'b0);
        waited = 0;
        while (!keyReady && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        checkValue("keyReady latency", waited, 10);
    endtask

    // inReady depends only on registers, so it is read at the driving edge
    task automatic sendRequest(stimRowT r);
        aesReqT req;
        logic sent;
        req.data = r.din;
        req.decrypt = r.decrypt;
        req.chain = r.chain;
        inReq = req;
        inValid = 1'b1;
        sent = 1'b0;
        while (!sent) begin
            sent = inReady;
            @(negedge clk);
        end
        inValid = 1'b0;
    endtask

    // the output side drives a random ready, compares blocks in order
    // and checks that a refused block is held
    initial begin : collect
        int rnd;
        logic held;
        blockT heldData;
        held = 1'b0;
        heldData = '0;
        wait (rst == 1'b0);
        while (outIdx < numRows) begin
            @(negedge clk);
            if (held) begin
                checkValue("outValid", outValid, 1'b1);
                checkValue("outBlock", outBlock, heldData);
            end
            rnd = $random(seed);
            outReady = rnd[0];
            if (outValid && outReady) begin
                checkValue("outBlock", outBlock, stim[outIdx].expBlock);
                outIdx++;
            end
            held = outValid && !outReady;
            heldData = outBlock;
        end
    end

    initial begin : watchdog
        wait (cycleLimit > 0 && cycleCount >= cycleLimit);
        $display("timeout after %0d cycles with %0d of %0d blocks received",
                 cycleCount, outIdx, numRows);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        key = '0;
        keyLoad = 1'b0;
        inValid = 1'b0;
        inReq = '0;
        outReady = 1'b0;
        fillStimulus();
        cycleLimit = timeoutCycles();

        repeat (5) @(negedge clk);
        rst = 1'b0;
        checkValue("outValid", outValid, 1'b0);
        checkValue("keyReady", keyReady, 1'b0);
        // the input buffer is empty, so it can take a word straight away
        checkValue("inReady", inReady, 1'b1);

        for (int i = 0; i < numRows; i++) begin
            if (stim[i].newKey) begin
                // a new key is only loaded with the core drained
                while (outIdx != i) begin
                    @(negedge clk);
                end
                loadCipherKey(stim[i].key);
            end
            sendRequest(stim[i]);
        end

        wait (outIdx == numRows);
        @(negedge clk);
        outReady = 1'b1;
        repeat (20) begin
            checkValue("outValid", outValid, 1'b0);
            @(negedge clk);
        end

        $display("checks run: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- aesCbcTop.sv
// AES-128 CBC block cipher top level
// joins the input buffer, the cipher core and the output buffer
`timescale 1ns/1ns

module aesCbcTop
    import aesStreamPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  blockT  key,
    input  logic   keyLoad,
    output logic   keyReady,
    input  logic   inValid,
    output logic   inReady,
    input  aesReqT inReq,
    output logic   outValid,
    input  logic   outReady,
    output blockT  outBlock
);

    logic   reqValid;
    logic   reqReady;
    aesReqT reqData;
    logic   respValid;
    logic   respReady;
    blockT  respData;

    wordBuffer #(.payloadT(aesReqT)) reqBuf (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inReq),
        .outValid (reqValid),
        .outReady (reqReady),
        .outData  (reqData)
    );

    cbcCipher core (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .keyLoad   (keyLoad),
        .keyReady  (keyReady),
        .reqValid  (reqValid),
        .reqReady  (reqReady),
        .reqData   (reqData),
        .respValid (respValid),
        .respReady (respReady),
        .respData  (respData)
    );

    wordBuffer #(.payloadT(blockT)) respBuf (
        .clk      (clk),
        .rst      (rst),
        .inValid  (respValid),
        .inReady  (respReady),
        .inData   (respData),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outBlock)
    );

endmodule

//--- aesMathPkg.sv
// AES arithmetic over GF(2^8) and the byte-level round transforms
// the S-boxes are computed from the field inverse and the affine map
`include "aes_cfg.svh"

package aesMathPkg;

    typedef logic [`AES_BYTE_BITS-1:0] byteT;
    typedef logic [`AES_COL_WORDS*`AES_BYTE_BITS-1:0] wordT;
    typedef logic [3:0] roundIdxT;

    localparam int byteBits = `AES_BYTE_BITS;
    localparam int wordBits = $bits(wordT);
    localparam int blockTop = `AES_BLOCK_BITS - 1;
    localparam int numCols = `AES_BLOCK_BITS / wordBits;

    // multiply by x modulo the AES polynomial x^8 + x^4 + x^3 + x + 1
    function automatic byteT xtime(byteT a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic byteT gfMul(byteT a, byteT b);
        byteT p;
        byteT m;
        p = '0;
        m = a;
        for (int i = 0; i < byteBits; i++) begin
            if (b[i]) begin
                p = p ^ m;
            end
            m = xtime(m);
        end
        return p;
    endfunction

    // a^254 is the multiplicative inverse and maps zero onto zero
    function automatic byteT gfInv(byteT a);
        byteT sq;
        byteT r;
        sq = a;
        r = 8'h01;
        for (int i = 1; i < byteBits; i++) begin
            sq = gfMul(sq, sq);
            r = gfMul(r, sq);
        end
        return r;
    endfunction

    function automatic byteT rotl(byteT a, int n);
        return (a << n) | (a >> (byteBits - n));
    endfunction

    function automatic byteT sbox(byteT a);
        byteT v;
        v = gfInv(a);
        return v ^ rotl(v, 1) ^ rotl(v, 2) ^ rotl(v, 3) ^ rotl(v, 4) ^ 8'h63;
    endfunction

    // undo the affine map first, then invert
    function automatic byteT invSbox(byteT a);
        return gfInv(rotl(a, 1) ^ rotl(a, 3) ^ rotl(a, 6) ^ 8'h05);
    endfunction

    function automatic wordT subWord(wordT w);
        wordT o;
        for (int r = 0; r < wordBits / byteBits; r++) begin
            o[wordBits-1-byteBits*r -: byteBits] = sbox(w[wordBits-1-byteBits*r -: byteBits]);
        end
        return o;
    endfunction

    function automatic logic [blockTop:0] subBytes(logic [blockTop:0] s);
        logic [blockTop:0] o;
        for (int k = 0; k < `AES_BLOCK_BITS / byteBits; k++) begin
            o[blockTop-byteBits*k -: byteBits] = sbox(s[blockTop-byteBits*k -: byteBits]);
        end
        return o;
    endfunction

    function automatic logic [blockTop:0] invSubBytes(logic [blockTop:0] s);
        logic [blockTop:0] o;
        for (int k = 0; k < `AES_BLOCK_BITS / byteBits; k++) begin
            o[blockTop-byteBits*k -: byteBits] = invSbox(s[blockTop-byteBits*k -: byteBits]);
        end
        return o;
    endfunction

    // row r of column c takes the byte from column c + r, or c - r when inverse
    function automatic logic [blockTop:0] rowShift(logic [blockTop:0] s, logic inverse);
        logic [blockTop:0] o;
        int src;
        for (int c = 0; c < numCols; c++) begin
            for (int r = 0; r < numCols; r++) begin
                src = inverse ? (c + numCols - r) % numCols : (c + r) % numCols;
                o[blockTop-wordBits*c-byteBits*r -: byteBits] =
                    s[blockTop-wordBits*src-byteBits*r -: byteBits];
            end
        end
        return o;
    endfunction

    function automatic logic [blockTop:0] shiftRows(logic [blockTop:0] s);
        return rowShift(s, 1'b0);
    endfunction

    function automatic logic [blockTop:0] invShiftRows(logic [blockTop:0] s);
        return rowShift(s, 1'b1);
    endfunction

    // forward matrix rows are 2 3 1 1 rotated, inverse rows are e b d 9 rotated
    function automatic wordT mixWord(wordT w, logic inverse);
        byteT a [4];
        wordT o;
        for (int r = 0; r < 4; r++) begin
            a[r] = w[wordBits-1-byteBits*r -: byteBits];
        end
        for (int r = 0; r < 4; r++) begin
            if (inverse) begin
                o[wordBits-1-byteBits*r -: byteBits] =
                    gfMul(a[r], 8'h0e) ^ gfMul(a[(r+1)%4], 8'h0b) ^
                    gfMul(a[(r+2)%4], 8'h0d) ^ gfMul(a[(r+3)%4], 8'h09);
            end else begin
                o[wordBits-1-byteBits*r -: byteBits] =
                    xtime(a[r]) ^ xtime(a[(r+1)%4]) ^ a[(r+1)%4] ^ a[(r+2)%4] ^ a[(r+3)%4];
            end
        end
        return o;
    endfunction

    function automatic logic [blockTop:0] mixState(logic [blockTop:0] s, logic inverse);
        logic [blockTop:0] o;
        for (int c = 0; c < numCols; c++) begin
            o[blockTop-wordBits*c -: wordBits] = mixWord(s[blockTop-wordBits*c -: wordBits], inverse);
        end
        return o;
    endfunction

    function automatic logic [blockTop:0] mixColumns(logic [blockTop:0] s);
        return mixState(s, 1'b0);
    endfunction

    function automatic logic [blockTop:0] invMixColumns(logic [blockTop:0] s);
        return mixState(s, 1'b1);
    endfunction

endpackage

//--- aesRound.sv
// one combinational AES round in either direction
// the final round leaves out the column mix
`timescale 1ns/1ns

module aesRound
    import aesStreamPkg::*;
    import aesMathPkg::*;
(
    input  blockT state,
    input  blockT roundKey,
    input  logic  decrypt,
    input  logic  finalRound,
    output blockT result
);

    blockT fwdShifted;
    blockT fwdMixed;
    blockT fwdOut;
    blockT invSubbed;
    blockT invKeyed;
    blockT invOut;

    // forward order is substitute, shift rows, mix columns, add key
    assign fwdShifted = shiftRows(subBytes(state));
    assign fwdMixed = finalRound ? fwdShifted : mixColumns(fwdShifted);
    assign fwdOut = fwdMixed ^ roundKey;

    // inverse order with the key added before the inverse column mix
    // so the schedule is used as stored, with no mixed decryption keys
    assign invSubbed = invSubBytes(invShiftRows(state));
    assign invKeyed = invSubbed ^ roundKey;
    assign invOut = finalRound ? invKeyed : invMixColumns(invKeyed);

    assign result = decrypt ? invOut : fwdOut;

endmodule

//--- aesStreamPkg.sv
// block-level stream types passed between the buffers and the cipher core
// a request carries its own direction and chaining mode
`include "aes_cfg.svh"

package aesStreamPkg;

    // one data block, also the width of a cipher key
    typedef logic [`AES_BLOCK_BITS-1:0] blockT;

    // request into the core
    // chain selects CBC for this block, otherwise it is handled as plain ECB
    typedef struct packed {
        blockT data;
        logic  decrypt;
        logic  chain;
    } aesReqT;

endpackage

//--- aes_cfg.svh
// AES-128 sizing constants shared by the packages and the cipher core
// block and key width are equal in the 128-bit variant
`ifndef AES_CFG_SVH
`define AES_CFG_SVH

// state and key width in bits
`define AES_BLOCK_BITS 128

// width of one state byte
`define AES_BYTE_BITS 8

// 32-bit words per key, also bytes per state column
`define AES_COL_WORDS 4

// number of full rounds after the initial key addition
`define AES_ROUNDS 10

`endif

//--- cbcCipher.sv
// iterative AES-128 core with CBC chaining, one round per clock
// takes one block at a time and holds the result until it is taken
`timescale 1ns/1ns
`include "aes_cfg.svh"

module cbcCipher
    import aesStreamPkg::*;
    import aesMathPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  blockT  key,
    input  logic   keyLoad,
    output logic   keyReady,
    input  logic   reqValid,
    output logic   reqReady,
    input  aesReqT reqData,
    output logic   respValid,
    input  logic   respReady,
    output blockT  respData
);

    localparam roundIdxT lastRound = roundIdxT'(`AES_ROUNDS);

    logic     busy;
    logic     accept;
    logic     lastStep;
    roundIdxT roundCnt;
    roundIdxT roundSel;
    logic     decryptQ;
    logic     chainQ;
    blockT    state;
    blockT    chainVal;
    blockT    savedIn;
    blockT    roundKey;
    blockT    roundOut;

    keyExpander keys (
        .clk      (clk),
        .rst      (rst),
        .key      (key),
        .keyLoad  (keyLoad),
        .keyReady (keyReady),
        .roundSel (roundSel),
        .roundKey (roundKey)
    );

    aesRound roundUnit (
        .state      (state),
        .roundKey   (roundKey),
        .decrypt    (decryptQ),
        .finalRound (roundCnt == lastRound),
        .result     (roundOut)
    );

    assign reqReady = keyReady && !busy && !respValid;
    assign accept = reqValid && reqReady;
    assign lastStep = busy && (roundCnt == lastRound);
    assign respData = state;

    // step 0 is the initial key addition, then rounds 1 to 10
    // decryption walks the schedule from key 10 down to key 0
    assign roundSel = decryptQ ? lastRound - roundCnt : roundCnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            roundCnt <= '0;
            respValid <= 1'b0;
        end else begin
            if (accept) begin
                busy <= 1'b1;
                roundCnt <= '0;
            end else if (lastStep) begin
                busy <= 1'b0;
                respValid <= 1'b1;
            end else if (busy) begin
                roundCnt <= roundCnt + 1'b1;
            end
            if (respValid && respReady) begin
                respValid <= 1'b0;
            end
        end
    end

    // the state register doubles as the result register once the rounds end
    always_ff @(posedge clk) begin
        if (accept) begin
            state <= (reqData.chain && !reqData.decrypt) ? reqData.data ^ chainVal
                                                         : reqData.data;
            savedIn <= reqData.data;
            decryptQ <= reqData.decrypt;
            chainQ <= reqData.chain;
        end else if (busy) begin
            if (roundCnt == '0) begin
                state <= state ^ roundKey;
            end else if (lastStep && chainQ && decryptQ) begin
                state <= roundOut ^ chainVal;
            end else begin
                state <= roundOut;
            end
        end
    end

    // a fresh key acts as an all-zero IV
    // ciphertext always feeds the chain
    // it is the output when encrypting and the input when decrypting
    always_ff @(posedge clk) begin
        if (keyLoad) begin
            chainVal <= '0;
        end else if (lastStep && chainQ) begin
            chainVal <= decryptQ ? savedIn : roundOut;
        end
    end

endmodule

//--- keyExpander.sv
// AES-128 key schedule that expands a loaded key into eleven round keys
// one key is produced per cycle and any stored key can be read by index
`timescale 1ns/1ns
`include "aes_cfg.svh"

module keyExpander
    import aesStreamPkg::*;
    import aesMathPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  blockT    key,
    input  logic     keyLoad,
    output logic     keyReady,
    input  roundIdxT roundSel,
    output blockT    roundKey
);

    localparam roundIdxT lastRound = roundIdxT'(`AES_ROUNDS);

    blockT    keyMem [0:`AES_ROUNDS];
    blockT    prevKey;
    blockT    nextKey;
    byteT     rcon;
    roundIdxT genIdx;

    // each new word is the word before it XOR the same word of the previous key
    // the first one starts from the rotated, substituted last word plus rcon
    always_comb begin
        wordT acc;
        acc = subWord({prevKey[wordBits-byteBits-1:0], prevKey[wordBits-1 -: byteBits]}) ^
              {rcon, {(wordBits - byteBits){1'b0}}};
        for (int i = 0; i < `AES_COL_WORDS; i++) begin
            acc = acc ^ prevKey[`AES_BLOCK_BITS-1-wordBits*i -: wordBits];
            nextKey[`AES_BLOCK_BITS-1-wordBits*i -: wordBits] = acc;
        end
    end

    // genIdx is the key being written, zero while the schedule is idle
    always_ff @(posedge clk) begin
        if (rst) begin
            genIdx <= '0;
            keyReady <= 1'b0;
        end else if (keyLoad) begin
            genIdx <= roundIdxT'(1);
            keyReady <= 1'b0;
        end else if (genIdx != '0) begin
            if (genIdx == lastRound) begin
                genIdx <= '0;
                keyReady <= 1'b1;
            end else begin
                genIdx <= genIdx + 1'b1;
            end
        end
    end

    // the previous key is kept in a register so the table needs only one read port
    always_ff @(posedge clk) begin
        if (keyLoad) begin
            keyMem[0] <= key;
            prevKey <= key;
            rcon <= 8'h01;
        end else if (genIdx != '0) begin
            keyMem[genIdx] <= nextKey;
            prevKey <= nextKey;
            rcon <= xtime(rcon);
        end
    end

    assign roundKey = keyMem[roundSel];

endmodule

//--- project.f
+incdir+.
aesStreamPkg.sv
aesMathPkg.sv
wordBuffer.sv
keyExpander.sv
aesRound.sv
cbcCipher.sv
aesCbcTop.sv
aesCbcTb.sv

//--- wordBuffer.sv
// one-entry valid/ready holding buffer
// a new word is taken in the same cycle that the held word leaves
`timescale 1ns/1ns

module wordBuffer
    import aesStreamPkg::*;
#(
    parameter type payloadT = blockT
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    full;
    payloadT held;
    logic    inFire;

    // when full, the slot frees up only if the consumer takes the word now
    assign inReady = !full || outReady;
    assign inFire = inValid && inReady;
    assign outValid = full;
    assign outData = held;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (inFire) begin
            full <= 1'b1;
        end else if (outReady) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inFire) begin
            held <= inData;
        end
    end

endmodule
